// ==== sim.f ====
+incdir+include
logic/opb_pkg.sv
logic/mgt_pkg.sv
logic/opb_attach.sv
logic/mgt_status_attach.sv
logic/mgt_param_apply.sv
logic/mgt_ctrl_top.sv
verification/mgt_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the transceiver control testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f sim.f \
  --top-module mgt_ctrl_tb \
  -o sim_mgt_ctrl

./obj_dir/sim_mgt_ctrl > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "run_sim.sh: testbench reported failure"
  exit 1
fi

if ! grep -q "Simulation PASSED" sim.log; then
  echo "run_sim.sh: no result line in sim.log"
  exit 1
fi

exit 0

// ==== include/mgt_ctrl_tb_tasks.svh ====
`ifndef MGT_CTRL_TB_TASKS_SVH
`define MGT_CTRL_TB_TASKS_SVH

// xorshift32 step
function automatic logic [31:0] xorshift(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// legal bits of each setting register
function automatic logic [3:0] set_mask(input logic [1:0] sel);
  case (sel)
    2'd0: return 4'((1 << mgt_pkg::RXEQMIX_W) - 1);
    2'd1: return 4'((1 << mgt_pkg::RXEQPOLE_W) - 1);
    2'd2: return 4'((1 << mgt_pkg::TXPREEMPH_W) - 1);
    default: return 4'((1 << mgt_pkg::TXDIFF_W) - 1);
  endcase
endfunction

// read value as the register map defines it
function automatic logic [31:0] expected_read(input logic [31:0] addr);
  logic [31:0] v;
  logic [1:0]  sel;
  v = 32'd0;
  sel = addr[3:2];
  if (addr >= SET_BASE && addr <= SET_HIGH) begin
    v = {28'd0, m_set[sel]};
  end else if (addr >= STAT_BASE && addr <= STAT_HIGH) begin
    case (sel)
      2'd0: v = {30'd0, busy_exp, rx_lock};  // busy above lock
      2'd1: v = {16'd0, err_model};
      default: v = 32'd0;
    endcase
  end
  return v;
endfunction

// called 2 ns after a rising edge, returns at the same phase
task automatic opb_write(input logic [31:0] addr, input logic [31:0] data,
                         input logic [0:3] be, output bit acked);
  int n;
  acked = 1'b0;
  n = 0;
  OPB_ABus   = addr;
  OPB_DBus   = data;
  OPB_BE     = be;
  OPB_RNW    = 1'b0;
  OPB_select = 1'b1;
  while (!acked && n < ACK_TIMEOUT) begin
    @(negedge OPB_Clk);
    if (Sl_xferAck) acked = 1'b1;
    n++;
  end
  @(posedge OPB_Clk);
  #2;
  OPB_select = 1'b0;
  OPB_ABus   = 32'd0;
  OPB_DBus   = 32'd0;
  OPB_BE     = 4'd0;
  OPB_RNW    = 1'b1;
endtask

task automatic opb_read(input logic [31:0] addr, output logic [31:0] data,
                        output bit acked);
  int n;
  acked = 1'b0;
  data = 32'd0;
  n = 0;
  OPB_ABus   = addr;
  OPB_BE     = 4'hF;
  OPB_RNW    = 1'b1;
  OPB_select = 1'b1;
  while (!acked && n < ACK_TIMEOUT) begin
    @(negedge OPB_Clk);
    if (Sl_xferAck) begin
      acked = 1'b1;
      data = Sl_DBus;  // valid only in the ack cycle
    end
    n++;
  end
  @(posedge OPB_Clk);
  #2;
  OPB_select = 1'b0;
  OPB_ABus   = 32'd0;
  OPB_BE     = 4'd0;
endtask

`endif

// ==== verification/mgt_ctrl_tb.sv ====
`timescale 1ns/1ps

module mgt_ctrl_tb;

  localparam logic [31:0] SET_BASE  = 32'h0000_1000;
  localparam logic [31:0] SET_HIGH  = 32'h0000_100F;
  localparam logic [31:0] STAT_BASE = 32'h0000_2000;
  localparam logic [31:0] STAT_HIGH = 32'h0000_200F;
  localparam int APPLY_CYCLES = 8;
  localparam int ACK_TIMEOUT  = 20;

  logic        OPB_Clk;
  logic        reset;
  logic [0:31] OPB_ABus;
  logic [0:3]  OPB_BE;
  logic [0:31] OPB_DBus;
  logic        OPB_RNW;
  logic        OPB_select;
  logic        OPB_seqAddr;
  logic        rx_lock;
  logic        rx_err;
  logic [0:31] Sl_DBus;
  logic        Sl_xferAck;
  logic        Sl_errAck;
  logic        Sl_retry;
  logic        Sl_toutSup;
  logic [1:0]  rxeqmix;
  logic [3:0]  rxeqpole;
  logic [2:0]  txpreemphasis;
  logic [2:0]  txdiffctrl;
  logic        pma_reset;

  logic [3:0]  m_set [4];  // settings model
  logic [15:0] err_model;
  logic        busy_exp;
  logic        line_active;
  logic        err_flood;
  logic [31:0] stim_rng;
  logic [31:0] line_rng;
  logic [31:0] rd_addr_q [$];
  logic [31:0] rd_got_q [$];
  logic [31:0] rd_exp_q [$];
  int          errors;
  int          checks;

  `include "mgt_ctrl_tb_tasks.svh"

  mgt_ctrl_top #(
    .SET_BASEADDR  (SET_BASE),
    .SET_HIGHADDR  (SET_HIGH),
    .STAT_BASEADDR (STAT_BASE),
    .STAT_HIGHADDR (STAT_HIGH),
    .APPLY_CYCLES  (APPLY_CYCLES)
  ) dut0 (
    .OPB_Clk       (OPB_Clk),
    .reset         (reset),
    .OPB_ABus      (OPB_ABus),
    .OPB_BE        (OPB_BE),
    .OPB_DBus      (OPB_DBus),
    .OPB_RNW       (OPB_RNW),
    .OPB_select    (OPB_select),
    .OPB_seqAddr   (OPB_seqAddr),
    .rx_lock       (rx_lock),
    .rx_err        (rx_err),
    .Sl_DBus       (Sl_DBus),
    .Sl_xferAck    (Sl_xferAck),
    .Sl_errAck     (Sl_errAck),
    .Sl_retry      (Sl_retry),
    .Sl_toutSup    (Sl_toutSup),
    .rxeqmix       (rxeqmix),
    .rxeqpole      (rxeqpole),
    .txpreemphasis (txpreemphasis),
    .txdiffctrl    (txdiffctrl),
    .pma_reset     (pma_reset)
  );

  initial begin
    OPB_Clk = 1'b0;
    forever #20 OPB_Clk = !OPB_Clk;
  end

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge OPB_Clk);
    #2;
  endtask

  task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [0:3] be);
    if (addr >= SET_BASE && addr <= SET_HIGH && be[3]) begin
      m_set[addr[3:2]] = data[3:0] & set_mask(addr[3:2]);
    end
  endtask

  task automatic check_acked(input bit acked, input logic [31:0] addr);
    checks++;
    assert (acked) else begin
      errors++;
      $display("ERROR at %0t: no acknowledge for address %h", $time, addr);
    end
  endtask

  task automatic check_ports();
    checks++;
    assert ({2'b00, rxeqmix} == m_set[0] && rxeqpole == m_set[1] &&
            {1'b0, txpreemphasis} == m_set[2] && {1'b0, txdiffctrl} == m_set[3]) else begin
      errors++;
      $display("Mismatch at %0t: setting ports %h %h %h %h, model %h %h %h %h", $time,
               rxeqmix, rxeqpole, txpreemphasis, txdiffctrl,
               m_set[0], m_set[1], m_set[2], m_set[3]);
    end
  endtask

  task automatic read_and_queue(input logic [31:0] addr);
    logic [31:0] got;
    bit          acked;
    opb_read(addr, got, acked);
    check_acked(acked, addr);
    rd_addr_q.push_back(addr);
    rd_got_q.push_back(got);
    rd_exp_q.push_back(expected_read(addr));
  endtask

  // transceiver model with its own random stream for errors and lock
  always @(posedge OPB_Clk) begin
    #2;
    if (reset) begin
      rx_err = 1'b0;
    end else if (err_flood) begin
      rx_err = 1'b1;  // an error on every cycle
      if (err_model != 16'hFFFF) err_model++;
    end else if (!line_active) begin
      rx_err = 1'b0;
    end else begin
      line_rng = xorshift(line_rng);
      rx_err = (line_rng[2:0] == 3'd0);
      if (line_rng[9:6] == 4'd0) rx_lock = !rx_lock;
      if (rx_err && err_model != 16'hFFFF) err_model++;
    end
  end

  // compares queued reads against the model
  always @(negedge OPB_Clk) begin : compare_reads
    logic [31:0] a;
    logic [31:0] got;
    logic [31:0] exp;
    while (rd_got_q.size() > 0) begin
      a = rd_addr_q.pop_front();
      got = rd_got_q.pop_front();
      exp = rd_exp_q.pop_front();
      checks++;
      assert (got == exp) else begin
        errors++;
        $display("Mismatch at %0t: read %h got %h expected %h", $time, a, got, exp);
      end
    end
  end

  // pma_reset pulse rule and idle bus outputs
  always @(negedge OPB_Clk) begin : pulse_monitor
    logic [11:0] cur;
    logic [11:0] prev;
    int          left;
    cur = {rxeqmix, rxeqpole, txpreemphasis, txdiffctrl};
    if (reset) begin
      prev = {mgt_pkg::RXEQMIX_RST, mgt_pkg::RXEQPOLE_RST,
              mgt_pkg::TXPREEMPH_RST, mgt_pkg::TXDIFF_RST};
      left = 0;
    end else begin
      assert (pma_reset == (left > 0)) else begin
        errors++;
        $display("Mismatch at %0t: pma_reset is %b, expected %b", $time, pma_reset, left > 0);
      end
      if (!Sl_xferAck) begin
        assert (Sl_DBus == 32'd0) else begin
          errors++;
          $display("Mismatch at %0t: Sl_DBus %h outside acknowledge", $time, Sl_DBus);
        end
      end
      assert (!Sl_errAck && !Sl_retry && !Sl_toutSup) else begin
        errors++;
        $display("Mismatch at %0t: errAck %b retry %b toutSup %b, expected all low", $time,
                 Sl_errAck, Sl_retry, Sl_toutSup);
      end
      if (cur != prev) left = APPLY_CYCLES;
      else if (left > 0) left--;
      prev = cur;
    end
  end

  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    logic [0:3]  be;
    bit          acked;
    errors = 0;
    checks = 0;
    reset = 1'b1;
    OPB_ABus = 32'd0;
    OPB_BE = 4'd0;
    OPB_DBus = 32'd0;
    OPB_RNW = 1'b1;
    OPB_select = 1'b0;
    OPB_seqAddr = 1'b0;
    rx_lock = 1'b1;
    rx_err = 1'b0;
    line_active = 1'b0;
    err_flood = 1'b0;
    busy_exp = 1'b0;
    err_model = 16'd0;
    stim_rng = 32'd93;
    line_rng = xorshift(32'd93);
    m_set[0] = {2'b00, mgt_pkg::RXEQMIX_RST};
    m_set[1] = mgt_pkg::RXEQPOLE_RST;
    m_set[2] = {1'b0, mgt_pkg::TXPREEMPH_RST};
    m_set[3] = {1'b0, mgt_pkg::TXDIFF_RST};
    idle_cycles(3);
    reset = 1'b0;
    idle_cycles(2);

    // reset values and an idle status
    for (int i = 0; i < 4; i++) read_and_queue(SET_BASE + 32'(4 * i));
    read_and_queue(STAT_BASE);
    read_and_queue(STAT_BASE + 32'd4);
    check_ports();

    // random writes with random byte enables
    line_active = 1'b1;
    for (int i = 0; i < 40; i++) begin
      stim_rng = xorshift(stim_rng);
      addr = SET_BASE + {28'd0, stim_rng[1:0], 2'b00};
      be = stim_rng[7:4];
      stim_rng = xorshift(stim_rng);
      data = stim_rng;
      opb_write(addr, data, be, acked);
      check_acked(acked, addr);
      model_write(addr, data, be);
      check_ports();
      read_and_queue(addr);
      if (stim_rng[9:8] == 2'd0) idle_cycles(10);  // let some pulses finish
    end

    // rewriting an unchanged value must give no pulse
    idle_cycles(12);
    opb_write(SET_BASE + 32'd12, {28'd0, m_set[3]}, 4'hF, acked);
    check_acked(acked, SET_BASE + 32'd12);
    idle_cycles(12);

    // status and error counter with the line frozen
    line_active = 1'b0;
    idle_cycles(3);
    read_and_queue(STAT_BASE);
    read_and_queue(STAT_BASE + 32'd4);
    opb_write(SET_BASE + 32'd8, {28'd0, (m_set[2] + 4'd1) & 4'h7}, 4'hF, acked);
    check_acked(acked, SET_BASE + 32'd8);
    model_write(SET_BASE + 32'd8, {28'd0, (m_set[2] + 4'd1) & 4'h7}, 4'hF);
    busy_exp = 1'b1;
    read_and_queue(STAT_BASE);
    idle_cycles(12);
    busy_exp = 1'b0;

    // hold rx_err high until the counter saturates
    err_flood = 1'b1;
    idle_cycles(65540);
    err_flood = 1'b0;
    idle_cycles(2);
    read_and_queue(STAT_BASE + 32'd4);

    opb_write(STAT_BASE + 32'd4, 32'd0, 4'hF, acked);
    check_acked(acked, STAT_BASE + 32'd4);
    err_model = 16'd0;
    read_and_queue(STAT_BASE + 32'd4);
    read_and_queue(STAT_BASE);

    // addresses outside both windows get no acknowledge
    opb_write(SET_HIGH + 32'd1, 32'hFFFF_FFFF, 4'hF, acked);
    checks++;
    assert (!acked) else begin
      errors++;
      $display("ERROR at %0t: address %h was acknowledged", $time, SET_HIGH + 32'd1);
    end
    opb_write(32'h0000_3000, 32'h0000_0005, 4'hF, acked);
    checks++;
    assert (!acked) else begin
      errors++;
      $display("ERROR at %0t: address 00003000 was acknowledged", $time);
    end
    check_ports();
    for (int i = 0; i < 4; i++) read_and_queue(SET_BASE + 32'(4 * i));

    idle_cycles(3);
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== logic/mgt_ctrl_top.sv ====
`timescale 1ns/1ps

module mgt_ctrl_top #(
  parameter logic [opb_pkg::ADDR_W-1:0] SET_BASEADDR  = 32'h0000_1000,
  parameter logic [opb_pkg::ADDR_W-1:0] SET_HIGHADDR  = 32'h0000_100F,
  parameter logic [opb_pkg::ADDR_W-1:0] STAT_BASEADDR = 32'h0000_2000,
  parameter logic [opb_pkg::ADDR_W-1:0] STAT_HIGHADDR = 32'h0000_200F,
  parameter int unsigned                APPLY_CYCLES  = 8
) (
  input  logic                              OPB_Clk,
  input  logic                              reset,
  input  logic [0:opb_pkg::ADDR_W-1]        OPB_ABus,
  input  logic [0:opb_pkg::BE_W-1]          OPB_BE,
  input  logic [0:opb_pkg::DATA_W-1]        OPB_DBus,
  input  logic                              OPB_RNW,
  input  logic                              OPB_select,
  input  logic                              OPB_seqAddr,
  input  logic                              rx_lock,
  input  logic                              rx_err,
  output logic [0:opb_pkg::DATA_W-1]        Sl_DBus,
  output logic                              Sl_xferAck,
  output logic                              Sl_errAck,
  output logic                              Sl_retry,
  output logic                              Sl_toutSup,
  output logic [mgt_pkg::RXEQMIX_W-1:0]     rxeqmix,
  output logic [mgt_pkg::RXEQPOLE_W-1:0]    rxeqpole,
  output logic [mgt_pkg::TXPREEMPH_W-1:0]   txpreemphasis,
  output logic [mgt_pkg::TXDIFF_W-1:0]      txdiffctrl,
  output logic                              pma_reset
);

  logic [0:opb_pkg::DATA_W-1] set_dbus;
  logic                       set_xferack;
  logic [0:opb_pkg::DATA_W-1] stat_dbus;
  logic                       stat_xferack;

  opb_attach #(
    .C_BASEADDR (SET_BASEADDR),
    .C_HIGHADDR (SET_HIGHADDR)
  ) set_slave (
    .OPB_Clk       (OPB_Clk),
    .reset         (reset),
    .OPB_ABus      (OPB_ABus),
    .OPB_BE        (OPB_BE),
    .OPB_DBus      (OPB_DBus),
    .OPB_RNW       (OPB_RNW),
    .OPB_select    (OPB_select),
    .OPB_seqAddr   (OPB_seqAddr),
    .Sl_DBus       (set_dbus),
    .Sl_xferAck    (set_xferack),
    .rxeqmix       (rxeqmix),
    .rxeqpole      (rxeqpole),
    .txpreemphasis (txpreemphasis),
    .txdiffctrl    (txdiffctrl)
  );

  mgt_status_attach #(
    .C_BASEADDR (STAT_BASEADDR),
    .C_HIGHADDR (STAT_HIGHADDR)
  ) stat_slave (
    .OPB_Clk    (OPB_Clk),
    .reset      (reset),
    .OPB_ABus   (OPB_ABus),
    .OPB_BE     (OPB_BE),
    .OPB_DBus   (OPB_DBus),
    .OPB_RNW    (OPB_RNW),
    .OPB_select (OPB_select),
    .rx_lock    (rx_lock),
    .rx_err     (rx_err),
    .pma_reset  (pma_reset),  // busy flag
    .Sl_DBus    (stat_dbus),
    .Sl_xferAck (stat_xferack)
  );

  mgt_param_apply #(
    .APPLY_CYCLES (APPLY_CYCLES)
  ) apply0 (
    .OPB_Clk       (OPB_Clk),
    .reset         (reset),
    .rxeqmix       (rxeqmix),
    .rxeqpole      (rxeqpole),
    .txpreemphasis (txpreemphasis),
    .txdiffctrl    (txdiffctrl),
    .pma_reset     (pma_reset)
  );

  // idle slaves drive zeros
  assign Sl_DBus    = set_dbus | stat_dbus;
  assign Sl_xferAck = set_xferack | stat_xferack;

  assign Sl_errAck  = 1'b0;
  assign Sl_retry   = 1'b0;
  assign Sl_toutSup = 1'b0;

endmodule

// ==== logic/mgt_param_apply.sv ====
`timescale 1ns/1ps

module mgt_param_apply #(
  parameter int unsigned APPLY_CYCLES = 8
) (
  input  logic                              OPB_Clk,
  input  logic                              reset,
  input  logic [mgt_pkg::RXEQMIX_W-1:0]     rxeqmix,
  input  logic [mgt_pkg::RXEQPOLE_W-1:0]    rxeqpole,
  input  logic [mgt_pkg::TXPREEMPH_W-1:0]   txpreemphasis,
  input  logic [mgt_pkg::TXDIFF_W-1:0]      txdiffctrl,
  output logic                              pma_reset
);

  localparam int CNT_W = $clog2(APPLY_CYCLES + 1);

  logic [mgt_pkg::RXEQMIX_W-1:0]   rxeqmix_q;
  logic [mgt_pkg::RXEQPOLE_W-1:0]  rxeqpole_q;
  logic [mgt_pkg::TXPREEMPH_W-1:0] txpreemph_q;
  logic [mgt_pkg::TXDIFF_W-1:0]    txdiff_q;
  logic                            changed;
  logic [CNT_W-1:0]                cnt;

  assign changed = (rxeqmix != rxeqmix_q) || (rxeqpole != rxeqpole_q) ||
                   (txpreemphasis != txpreemph_q) || (txdiffctrl != txdiff_q);

  // shadow starts at the reset values so reset alone gives no pulse
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      rxeqmix_q   <= mgt_pkg::RXEQMIX_RST;
      rxeqpole_q  <= mgt_pkg::RXEQPOLE_RST;
      txpreemph_q <= mgt_pkg::TXPREEMPH_RST;
      txdiff_q    <= mgt_pkg::TXDIFF_RST;
    end else begin
      rxeqmix_q   <= rxeqmix;
      rxeqpole_q  <= rxeqpole;
      txpreemph_q <= txpreemphasis;
      txdiff_q    <= txdiffctrl;
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (changed) begin
      cnt <= CNT_W'(APPLY_CYCLES);  // restart on every change
    end else if (cnt != '0) begin
      cnt <= cnt - CNT_W'(1);
    end
  end

  // high while counting APPLY_CYCLES down to 1
  assign pma_reset = (cnt != '0);

endmodule

// ==== logic/mgt_status_attach.sv ====
`timescale 1ns/1ps

module mgt_status_attach #(
  parameter logic [opb_pkg::ADDR_W-1:0] C_BASEADDR = '0,
  parameter logic [opb_pkg::ADDR_W-1:0] C_HIGHADDR = '0
) (
  input  logic                         OPB_Clk,
  input  logic                         reset,
  input  logic [0:opb_pkg::ADDR_W-1]   OPB_ABus,
  input  logic [0:opb_pkg::BE_W-1]     OPB_BE,
  input  logic [0:opb_pkg::DATA_W-1]   OPB_DBus,  // write data unused
  input  logic                         OPB_RNW,
  input  logic                         OPB_select,
  input  logic                         rx_lock,
  input  logic                         rx_err,
  input  logic                         pma_reset,
  output logic [0:opb_pkg::DATA_W-1]   Sl_DBus,
  output logic                         Sl_xferAck
);

  localparam int DW = opb_pkg::DATA_W;
  localparam int EW = mgt_pkg::ERRCNT_W;

  logic                          a_match;
  logic [opb_pkg::ADDR_W-1:0]    a_trans;
  logic [opb_pkg::REG_SEL_W-1:0] reg_sel;
  logic                          ack_next;
  logic                          err_clr;
  logic [mgt_pkg::ERRCNT_W-1:0]  errcnt;
  logic [DW-1:0]                 rd_data;

  assign a_match = (OPB_ABus >= C_BASEADDR) && (OPB_ABus <= C_HIGHADDR);
  assign a_trans = OPB_ABus - C_BASEADDR;
  assign reg_sel = a_trans[opb_pkg::REG_SEL_LSB +: opb_pkg::REG_SEL_W];

  assign ack_next = a_match && OPB_select && !Sl_xferAck;

  // clear request taken on the ack edge
  assign err_clr = ack_next && !OPB_RNW && OPB_BE[opb_pkg::LOW_BYTE_BE] &&
                   (reg_sel == mgt_pkg::REG_ERRCNT);

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      Sl_xferAck <= 1'b0;
    end else begin
      Sl_xferAck <= ack_next;
    end
  end

  // saturating error count with clear priority
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      errcnt <= '0;
    end else if (err_clr) begin
      errcnt <= '0;
    end else if (rx_err && (errcnt != '1)) begin
      errcnt <= errcnt + EW'(1);
    end
  end

  always_comb begin
    rd_data = '0;
    case (reg_sel)
      mgt_pkg::REG_STATUS: begin
        rd_data[mgt_pkg::STAT_LOCK_BIT] = rx_lock;    // bus bit 31
        rd_data[mgt_pkg::STAT_BUSY_BIT] = pma_reset;  // bus bit 30
      end
      mgt_pkg::REG_ERRCNT: begin
        rd_data[mgt_pkg::ERRCNT_W-1:0] = errcnt;
      end
      default: begin
        rd_data = '0;  // spare offsets read zero
      end
    endcase
  end

  assign Sl_DBus = Sl_xferAck ? rd_data : '0;

endmodule

// ==== logic/opb_attach.sv ====
`timescale 1ns/1ps

module opb_attach #(
  parameter logic [opb_pkg::ADDR_W-1:0] C_BASEADDR = '0,
  parameter logic [opb_pkg::ADDR_W-1:0] C_HIGHADDR = '0
) (
  input  logic                                OPB_Clk,
  input  logic                                reset,
  input  logic [0:opb_pkg::ADDR_W-1]          OPB_ABus,
  input  logic [0:opb_pkg::BE_W-1]            OPB_BE,
  input  logic [0:opb_pkg::DATA_W-1]          OPB_DBus,
  input  logic                                OPB_RNW,
  input  logic                                OPB_select,
  input  logic                                OPB_seqAddr,  // single beats only
  output logic [0:opb_pkg::DATA_W-1]          Sl_DBus,
  output logic                                Sl_xferAck,
  output logic [mgt_pkg::RXEQMIX_W-1:0]       rxeqmix,
  output logic [mgt_pkg::RXEQPOLE_W-1:0]      rxeqpole,
  output logic [mgt_pkg::TXPREEMPH_W-1:0]     txpreemphasis,
  output logic [mgt_pkg::TXDIFF_W-1:0]        txdiffctrl
);

  localparam int DW = opb_pkg::DATA_W;

  logic                          a_match;
  logic [opb_pkg::ADDR_W-1:0]    a_trans;
  logic [opb_pkg::REG_SEL_W-1:0] reg_sel;
  logic                          ack_next;
  logic                          wr_en;
  logic [DW-1:0]                 rd_data;

  assign a_match = (OPB_ABus >= C_BASEADDR) && (OPB_ABus <= C_HIGHADDR);
  assign a_trans = OPB_ABus - C_BASEADDR;
  assign reg_sel = a_trans[opb_pkg::REG_SEL_LSB +: opb_pkg::REG_SEL_W];

  // one ack per select, never two in a row
  assign ack_next = a_match && OPB_select && !Sl_xferAck;
  assign wr_en    = ack_next && !OPB_RNW && OPB_BE[opb_pkg::LOW_BYTE_BE];

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      Sl_xferAck <= 1'b0;
    end else begin
      Sl_xferAck <= ack_next;
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      rxeqmix       <= mgt_pkg::RXEQMIX_RST;
      rxeqpole      <= mgt_pkg::RXEQPOLE_RST;
      txpreemphasis <= mgt_pkg::TXPREEMPH_RST;
      txdiffctrl    <= mgt_pkg::TXDIFF_RST;
    end else if (wr_en) begin
      case (reg_sel)
        mgt_pkg::REG_RXEQMIX: begin
          rxeqmix <= OPB_DBus[DW-mgt_pkg::RXEQMIX_W +: mgt_pkg::RXEQMIX_W];
        end
        mgt_pkg::REG_RXEQPOLE: begin
          rxeqpole <= OPB_DBus[DW-mgt_pkg::RXEQPOLE_W +: mgt_pkg::RXEQPOLE_W];
        end
        mgt_pkg::REG_TXPREEMPH: begin
          txpreemphasis <= OPB_DBus[DW-mgt_pkg::TXPREEMPH_W +: mgt_pkg::TXPREEMPH_W];
        end
        mgt_pkg::REG_TXDIFFCTRL: begin
          txdiffctrl <= OPB_DBus[DW-mgt_pkg::TXDIFF_W +: mgt_pkg::TXDIFF_W];
        end
        default: begin
        end
      endcase
    end
  end

  // readback, zero extended into the low bits
  always_comb begin
    rd_data = '0;
    case (reg_sel)
      mgt_pkg::REG_RXEQMIX: begin
        rd_data[mgt_pkg::RXEQMIX_W-1:0] = rxeqmix;
      end
      mgt_pkg::REG_RXEQPOLE: begin
        rd_data[mgt_pkg::RXEQPOLE_W-1:0] = rxeqpole;
      end
      mgt_pkg::REG_TXPREEMPH: begin
        rd_data[mgt_pkg::TXPREEMPH_W-1:0] = txpreemphasis;
      end
      default: begin
        rd_data[mgt_pkg::TXDIFF_W-1:0] = txdiffctrl;
      end
    endcase
  end

  // lsb of rd_data lands on bus bit 31
  assign Sl_DBus = Sl_xferAck ? rd_data : '0;

endmodule

// ==== logic/mgt_pkg.sv ====
package mgt_pkg;

  // analog setting widths
  parameter int RXEQMIX_W   = 2;
  parameter int RXEQPOLE_W  = 4;
  parameter int TXPREEMPH_W = 3;
  parameter int TXDIFF_W    = 3;

  // values after reset
  parameter logic [RXEQMIX_W-1:0]   RXEQMIX_RST   = 2'b00;
  parameter logic [RXEQPOLE_W-1:0]  RXEQPOLE_RST  = 4'b0000;
  parameter logic [TXPREEMPH_W-1:0] TXPREEMPH_RST = 3'b000;
  parameter logic [TXDIFF_W-1:0]    TXDIFF_RST    = 3'b100;  // mid swing

  // settings slave register map
  parameter logic [opb_pkg::REG_SEL_W-1:0] REG_RXEQMIX    = 2'd0;
  parameter logic [opb_pkg::REG_SEL_W-1:0] REG_RXEQPOLE   = 2'd1;
  parameter logic [opb_pkg::REG_SEL_W-1:0] REG_TXPREEMPH  = 2'd2;
  parameter logic [opb_pkg::REG_SEL_W-1:0] REG_TXDIFFCTRL = 2'd3;

  // status slave register map
  parameter logic [opb_pkg::REG_SEL_W-1:0] REG_STATUS = 2'd0;
  parameter logic [opb_pkg::REG_SEL_W-1:0] REG_ERRCNT = 2'd1;

  // receive error counter
  parameter int ERRCNT_W = 16;

  // status register fields, counted from the lsb (bus bit 31)
  parameter int STAT_LOCK_BIT = 0;
  parameter int STAT_BUSY_BIT = 1;

endpackage

// ==== logic/opb_pkg.sv ====
package opb_pkg;

  // OPB bus sizes, bit 0 is the most significant bit on the bus
  parameter int DATA_W = 32;
  parameter int ADDR_W = 32;
  parameter int BE_W   = 4;

  // register select within a slave window
  parameter int REG_SEL_LSB = 2;  // word addressing
  parameter int REG_SEL_W   = 2;  // four registers per slave

  // byte lane holding bits 24..31, where every register lives
  parameter int LOW_BYTE_BE = BE_W - 1;

endpackage
